/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_cpu
FLIST := all.f
BUILD := obj_dir
PASS  := No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)

/* all.f */
+incdir+testbench
common/cpu_pkg.sv
hdl/ram_1rw.sv
hdl/mem_arbiter.sv
core/page_mmu.sv
core/core_seq.sv
hdl/cpu_top.sv
testbench/tb_cpu.sv

/* common/cpu_pkg.sv */
package cpu_pkg;

  // word and address geometry
  localparam int data_w      = 16;  // data and instruction word
  localparam int addr_w      = 10;  // 1024 word RAM
  localparam int page_bits   = 4;   // page field of an address
  localparam int offset_bits = 6;   // 64 words per page
  localparam int num_pages   = 16;  // physical pages
  localparam int reg_count   = 8;   // register file depth
  localparam int reg_idx_w   = 3;   // register index width

  // core sequencer states
  localparam logic [2:0] cs_idle      = 3'd0;  // waiting for start
  localparam logic [2:0] cs_fetch_op  = 3'd1;  // first instruction word
  localparam logic [2:0] cs_fetch_arg = 3'd2;  // operand word
  localparam logic [2:0] cs_exec      = 3'd3;  // decode and execute
  localparam logic [2:0] cs_mem       = 3'd4;  // data read or write

  // mmu states
  localparam logic [1:0] ms_idle    = 2'd0;  // no request in flight
  localparam logic [1:0] ms_alloc   = 2'd1;  // table entry just written
  localparam logic [1:0] ms_req     = 2'd2;  // waiting for arbiter grant
  localparam logic [1:0] ms_wait_rd = 2'd3;  // waiting for read data

  // opcode sits in the upper byte of the first word
  typedef enum logic [7:0] {
    op_jmp       = 8'd1,   // pc = operand
    op_ram2reg   = 8'd2,   // reg = mem[operand]
    op_reg2ram   = 8'd3,   // mem[operand] = reg
    op_num2reg   = 8'd4,   // reg = operand
    op_reg_plus  = 8'd5,   // reg += operand
    op_reg_minus = 8'd6,   // reg -= operand
    op_exit      = 8'd17   // halt the core
  } opcode_t;

  // one address word, seen flat or split into page and offset
  typedef union packed {
    logic [addr_w-1:0] flat;
    struct packed {
      logic [page_bits-1:0]   page;
      logic [offset_bits-1:0] offset;
    } paged;
  } mem_addr_u;

endpackage

/* core/core_seq.sv */
module core_seq
  import cpu_pkg::*;
(
  input  logic              clka,
  input  logic              rst_n,
  input  logic              start,
  output logic              core_req,     // held until rvalid or wdone
  output logic              core_we,
  output logic [addr_w-1:0] core_laddr,   // logical address
  output logic [data_w-1:0] core_wdata,
  input  logic [data_w-1:0] core_rdata,
  input  logic              core_rvalid,
  input  logic              core_wdone,
  output logic              busy,
  output logic              retire
);

  logic [2:0]           state;
  logic [addr_w-1:0]    pc;                    // logical program counter
  logic [data_w-1:0]    regs [reg_count];      // register file
  opcode_t              ir_op;                 // latched opcode
  logic [reg_idx_w-1:0] ir_reg;                // low bits of register number
  logic [data_w-1:0]    ir_arg;                // operand word
  logic                 done;                  // current request finished

  assign done = core_rvalid | core_wdone;

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cs_idle;
      core_req <= 1'b0;
      core_we  <= 1'b0;
      busy     <= 1'b0;
      retire   <= 1'b0;
      pc       <= '0;
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      retire <= 1'b0;  // single cycle strobe
      case (state)
        cs_idle: begin
          busy <= start;  // also drops busy the cycle after exit retired
          if (start) begin
            pc    <= '0;
            state <= cs_fetch_op;
          end
        end
        cs_fetch_op: begin
          if (!core_req) begin
            core_req <= 1'b1;  // read at pc
            core_we  <= 1'b0;
          end else if (done) begin
            core_req <= 1'b0;
            state    <= cs_fetch_arg;
          end
        end
        cs_fetch_arg: begin
          if (!core_req) begin
            core_req <= 1'b1;  // read at pc + 1
            core_we  <= 1'b0;
          end else if (done) begin
            core_req <= 1'b0;
            state    <= cs_exec;
          end
        end
        cs_exec: begin
          if (ir_op == op_ram2reg || ir_op == op_reg2ram) begin
            state <= cs_mem;  // needs a data access first
          end else begin
            retire <= 1'b1;
            pc     <= pc + addr_w'(2);
            state  <= cs_fetch_op;
            case (ir_op)
              op_jmp:       pc <= ir_arg[addr_w-1:0];
              op_num2reg:   regs[ir_reg] <= ir_arg;
              op_reg_plus:  regs[ir_reg] <= regs[ir_reg] + ir_arg;   // wraps at 16 bits
              op_reg_minus: regs[ir_reg] <= regs[ir_reg] - ir_arg;
              op_exit:      state <= cs_idle;
              default: ;  // unknown opcode just retires
            endcase
          end
        end
        cs_mem: begin
          if (!core_req) begin
            core_req <= 1'b1;
            core_we  <= (ir_op == op_reg2ram);
          end else if (done) begin
            core_req <= 1'b0;
            if (!core_we) begin
              regs[ir_reg] <= core_rdata;  // ram2reg result
            end
            retire <= 1'b1;
            pc     <= pc + addr_w'(2);
            state  <= cs_fetch_op;
          end
        end
        default: state <= cs_idle;
      endcase
    end
  end

  // instruction and request payload, stable while core_req is high
  always_ff @(posedge clka) begin
    case (state)
      cs_fetch_op: begin
        core_laddr <= pc;
        if (core_rvalid) begin
          ir_op  <= opcode_t'(core_rdata[data_w-1:8]);
          ir_reg <= core_rdata[reg_idx_w-1:0];
        end
      end
      cs_fetch_arg: begin
        core_laddr <= pc + addr_w'(1);
        if (core_rvalid) ir_arg <= core_rdata;
      end
      cs_mem: begin
        core_laddr <= ir_arg[addr_w-1:0];  // only low address bits used
        core_wdata <= regs[ir_reg];
      end
      default: ;
    endcase
  end

  // mmu answers only a request that is still up
  a_answer_held: assert property (@(posedge clka) disable iff (!rst_n)
    done |-> core_req);
  // read data never answers a write
  a_answer_kind: assert property (@(posedge clka) disable iff (!rst_n)
    core_rvalid |-> !core_we);

endmodule

/* core/page_mmu.sv */
module page_mmu
  import cpu_pkg::*;
(
  input  logic              clka,
  input  logic              rst_n,
  input  logic              core_req,
  input  logic              core_we,
  input  logic [addr_w-1:0] core_laddr,
  input  logic [data_w-1:0] core_wdata,
  output logic [data_w-1:0] core_rdata,
  output logic              core_rvalid,
  output logic              core_wdone,
  output logic              mmu_req,
  output logic              mmu_we,
  output logic [addr_w-1:0] mmu_addr,    // physical address
  output logic [data_w-1:0] mmu_wdata,
  input  logic              arb_gnt,
  input  logic              mmu_rvalid,
  input  logic [data_w-1:0] mmu_rdata
);

  logic [1:0]           state;
  mem_addr_u            laddr_u, paddr_u;
  logic [num_pages-1:0] pg_valid;                 // logical page mapped
  logic [page_bits-1:0] pg_map [num_pages];       // logical to physical page
  logic [page_bits:0]   next_free;                // one extra bit to see overflow
  logic                 hit, alloc;

  assign laddr_u = core_laddr;
  assign hit     = pg_valid[laddr_u.paged.page];
  assign alloc   = (state == ms_idle) && core_req && !hit;  // first touch

  always_comb begin
    paddr_u.paged.page   = pg_map[laddr_u.paged.page];
    paddr_u.paged.offset = laddr_u.paged.offset;  // offset passes unchanged
  end

  assign mmu_req     = (state == ms_req);
  assign mmu_we      = core_we;     // core holds these with core_req
  assign mmu_wdata   = core_wdata;
  assign core_wdone  = mmu_req && arb_gnt && core_we;  // write done at grant
  assign core_rvalid = (state == ms_wait_rd) && mmu_rvalid;
  assign core_rdata  = mmu_rdata;

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ms_idle;
      pg_valid  <= num_pages'(1);              // logical 0 on physical 0
      next_free <= (page_bits + 1)'(1);
      for (int i = 0; i < num_pages; i++) begin
        pg_map[i] <= '0;
      end
    end else begin
      case (state)
        ms_idle: begin
          if (core_req) begin
            if (hit) begin
              state <= ms_req;
            end else begin
              pg_valid[laddr_u.paged.page] <= 1'b1;
              pg_map[laddr_u.paged.page]   <= next_free[page_bits-1:0];  // lowest unused
              next_free                    <= next_free + 1'b1;
              state                        <= ms_alloc;
            end
          end
        end
        ms_alloc: state <= ms_req;  // entry is valid now
        ms_req: begin
          if (arb_gnt) state <= core_we ? ms_idle : ms_wait_rd;
        end
        ms_wait_rd: begin
          if (mmu_rvalid) state <= ms_idle;
        end
        default: state <= ms_idle;
      endcase
    end
  end

  // translated address latched on the way into ms_req
  always_ff @(posedge clka) begin
    if ((state == ms_idle && core_req && hit) || state == ms_alloc) begin
      mmu_addr <= paddr_u.flat;
    end
  end

  a_pages_left: assert property (@(posedge clka) disable iff (!rst_n)
    alloc |-> next_free < num_pages);

endmodule

/* hdl/cpu_top.sv */
module cpu_top
  import cpu_pkg::*;
(
  input  logic              clka,
  input  logic              rst_n,
  input  logic              start,             // begin program at logical 0
  input  logic              host_wr,
  input  logic              host_rd,
  input  logic [addr_w-1:0] host_addr,         // physical address
  input  logic [data_w-1:0] host_wdata,
  output logic [data_w-1:0] host_rdata,
  output logic              host_rdata_valid,
  output logic              busy,
  output logic              retire
);

  // core to mmu
  logic              core_req, core_we, core_rvalid, core_wdone;
  logic [addr_w-1:0] core_laddr;
  logic [data_w-1:0] core_wdata, core_rdata;

  // mmu to arbiter
  logic              mmu_req, mmu_we, arb_gnt, mmu_rvalid;
  logic [addr_w-1:0] mmu_addr;
  logic [data_w-1:0] mmu_wdata, mmu_rdata;

  // arbiter to ram
  logic              ram_en, ram_we;
  logic [addr_w-1:0] ram_addr;
  logic [data_w-1:0] ram_wdata, ram_rdata;

  core_seq u_core (
    .clka, .rst_n, .start,
    .core_req, .core_we, .core_laddr, .core_wdata,
    .core_rdata, .core_rvalid, .core_wdone,
    .busy, .retire
  );

  page_mmu u_mmu (
    .clka, .rst_n,
    .core_req, .core_we, .core_laddr, .core_wdata,
    .core_rdata, .core_rvalid, .core_wdone,
    .mmu_req, .mmu_we, .mmu_addr, .mmu_wdata,
    .arb_gnt, .mmu_rvalid, .mmu_rdata
  );

  mem_arbiter u_arb (
    .clka, .rst_n,
    .host_wr, .host_rd, .host_addr, .host_wdata, .host_rdata, .host_rdata_valid,
    .mmu_req, .mmu_we, .mmu_addr, .mmu_wdata, .arb_gnt, .mmu_rvalid, .mmu_rdata,
    .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

  ram_1rw u_ram (
    .clka, .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

endmodule

/* hdl/mem_arbiter.sv */
module mem_arbiter
  import cpu_pkg::*;
(
  input  logic              clka,
  input  logic              rst_n,
  input  logic              host_wr,
  input  logic              host_rd,
  input  logic [addr_w-1:0] host_addr,
  input  logic [data_w-1:0] host_wdata,
  output logic [data_w-1:0] host_rdata,
  output logic              host_rdata_valid,
  input  logic              mmu_req,
  input  logic              mmu_we,
  input  logic [addr_w-1:0] mmu_addr,
  input  logic [data_w-1:0] mmu_wdata,
  output logic              arb_gnt,
  output logic              mmu_rvalid,
  output logic [data_w-1:0] mmu_rdata,
  output logic              ram_en,
  output logic              ram_we,
  output logic [addr_w-1:0] ram_addr,
  output logic [data_w-1:0] ram_wdata,
  input  logic [data_w-1:0] ram_rdata
);

  logic host_acc;   // host uses the ram this cycle
  logic rd_valid_q; // ram_rdata valid now
  logic rd_host_q;  // owner of that read, 1 = host

  assign host_acc = host_wr | host_rd;
  assign arb_gnt  = mmu_req & ~host_acc;  // host always wins

  assign ram_en    = host_acc | mmu_req;
  assign ram_we    = host_acc ? host_wr    : mmu_we;
  assign ram_addr  = host_acc ? host_addr  : mmu_addr;
  assign ram_wdata = host_acc ? host_wdata : mmu_wdata;

  always_ff @(posedge clka or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
      rd_host_q  <= 1'b0;
    end else begin
      rd_valid_q <= host_rd | (arb_gnt & ~mmu_we);
      rd_host_q  <= host_rd;
    end
  end

  assign host_rdata_valid = rd_valid_q & rd_host_q;
  assign mmu_rvalid       = rd_valid_q & ~rd_host_q;
  assign host_rdata       = ram_rdata;
  assign mmu_rdata        = ram_rdata;

  // host strobes only while the core is halted
  a_host_first: assert property (@(posedge clka) disable iff (!rst_n)
    host_acc |-> !mmu_req);

endmodule

/* hdl/ram_1rw.sv */
module ram_1rw
  import cpu_pkg::*;
(
  input  logic              clka,
  input  logic              ram_en,
  input  logic              ram_we,
  input  logic [addr_w-1:0] ram_addr,
  input  logic [data_w-1:0] ram_wdata,
  output logic [data_w-1:0] ram_rdata  // valid one cycle after a read
);

  logic [data_w-1:0] mem [1 << addr_w];  // 1024 x 16

  always_ff @(posedge clka) begin
    if (ram_en) begin
      if (ram_we) begin
        mem[ram_addr] <= ram_wdata;
      end else begin
        ram_rdata <= mem[ram_addr];  // output holds during writes
      end
    end
  end

endmodule

/* testbench/tb_model.svh */
`ifndef tb_model_svh
`define tb_model_svh

logic [data_w-1:0]    reg_model [reg_count];  // expected register file
logic [num_pages-1:0] map_valid;              // logical page already mapped
logic [page_bits-1:0] map_page [num_pages];   // logical to physical page
int                   next_page;              // lowest unused physical page
int                   exec_count;             // instructions on the executed path
logic [data_w-1:0]    prog [$];               // program image from word 0
logic [addr_w-1:0]    pre_addr [$];           // words the host puts in before start
logic [data_w-1:0]    pre_data [$];
logic [addr_w-1:0]    exp_addr [$];           // words expected after the run
logic [data_w-1:0]    exp_data [$];

task automatic model_reset();
  for (int i = 0; i < reg_count; i++) begin
    reg_model[i] = '0;
  end
  for (int i = 0; i < num_pages; i++) begin
    map_page[i] = '0;
  end
  map_valid = num_pages'(1);  // logical 0 sits on physical 0
  next_page = 1;
endtask

// first touch takes the next free page, offset is kept
function automatic logic [addr_w-1:0] translate(input logic [addr_w-1:0] laddr);
  mem_addr_u la;
  mem_addr_u pa;
  la.flat = laddr;
  if (!map_valid[la.paged.page]) begin
    map_valid[la.paged.page] = 1'b1;
    map_page[la.paged.page]  = page_bits'(next_page);
    next_page++;
  end
  pa.paged.page   = map_page[la.paged.page];
  pa.paged.offset = la.paged.offset;
  return pa.flat;
endfunction

task automatic new_program();
  prog.delete();
  pre_addr.delete();
  pre_data.delete();
  exp_addr.delete();
  exp_data.delete();
  exec_count = 0;
endtask

// opcode and register byte first, operand second
task automatic encode(input logic [7:0] op, input logic [7:0] rbyte,
                      input logic [data_w-1:0] arg);
  prog.push_back({op, rbyte});
  prog.push_back(arg);
endtask

// emit one executed instruction and step the model, mem_word feeds ram2reg
task automatic run_instr(input logic [7:0] op, input logic [7:0] rbyte,
                         input logic [data_w-1:0] arg, input logic [data_w-1:0] mem_word);
  logic [reg_idx_w-1:0] r;
  r = rbyte[reg_idx_w-1:0];  // upper register bits ignored
  encode(op, rbyte, arg);
  exec_count++;
  case (op)
    op_num2reg:   reg_model[r] = arg;
    op_reg_plus:  reg_model[r] = reg_model[r] + arg;  // 16 bit wrap
    op_reg_minus: reg_model[r] = reg_model[r] - arg;
    op_ram2reg: begin
      pre_addr.push_back(translate(arg[addr_w-1:0]));
      pre_data.push_back(mem_word);
      reg_model[r] = mem_word;
    end
    op_reg2ram: begin
      exp_addr.push_back(translate(arg[addr_w-1:0]));
      exp_data.push_back(reg_model[r]);
    end
    default: ;  // jmp, exit and unknown opcodes leave registers alone
  endcase
endtask

`endif

/* testbench/tb_cpu.sv */
module tb_cpu
  import cpu_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_host_words = 24;
  localparam int n_arith_runs = 4;
  localparam int n_load_runs  = 3;
  localparam int n_jump_runs  = 3;
  localparam int n_page_runs  = 2;
  localparam int max_instr    = 32;   // one page of two word instructions
  localparam int instr_cycles = 24;   // three accesses, one with allocation
  localparam int host_cycles  = 400;  // load, preload and read back per run
  localparam int watchdog_cycles =
    (n_arith_runs + n_load_runs + n_jump_runs + n_page_runs)
    * (max_instr * instr_cycles + host_cycles) + n_host_words * 8 + 64;

  logic              clka, rst_n, start, host_wr, host_rd;
  logic [addr_w-1:0] host_addr;
  logic [data_w-1:0] host_wdata, host_rdata;
  logic              host_rdata_valid, busy, retire;
  int                retire_total = 0;  // retire strobes since time 0

  `include "tb_model.svh"

  cpu_top cpu_top_inst (
    .clka, .rst_n, .start, .host_wr, .host_rd, .host_addr, .host_wdata,
    .host_rdata, .host_rdata_valid, .busy, .retire
  );

  initial begin
    clka = 1'b0;
    forever #5 clka = ~clka;
  end

  always @(negedge clka) begin
    if (retire) retire_total <= retire_total + 1;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else
      stop_on_error($sformatf("Fail %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  function automatic logic [7:0] rand_reg_byte(input int r);
    return {(8 - reg_idx_w)'($urandom), reg_idx_w'(r)};  // junk above the index
  endfunction

  function automatic logic [data_w-1:0] rand_data_addr(input int offset);
    mem_addr_u a;
    a.paged.page   = page_bits'(1 + $urandom_range(14));  // page 0 holds the program
    a.paged.offset = offset_bits'(offset);
    return {(data_w - addr_w)'($urandom), a.flat};
  endfunction

  task automatic host_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    @(posedge clka);
    host_wr    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    @(posedge clka);
    host_wr    <= 1'b0;
  endtask

  task automatic host_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
    @(posedge clka);
    host_rd   <= 1'b1;
    host_addr <= addr;
    @(negedge clka);
    assert (!host_rdata_valid) else stop_on_error("read data valid came with the read strobe");
    @(posedge clka);
    host_rd <= 1'b0;
    @(negedge clka);
    assert (host_rdata_valid) else stop_on_error("read data valid missing one cycle after read");
    data = host_rdata;
    @(negedge clka);
    assert (!host_rdata_valid) else stop_on_error("read data valid held for more than a cycle");
  endtask

  task automatic reset_dut();
    @(posedge clka);
    rst_n <= 1'b0;
    repeat (2) @(posedge clka);
    rst_n <= 1'b1;
    model_reset();  // page map back to logical 0 only
  endtask

  // load the image, start, wait for the halt, then compare results
  task automatic run_program(input string name);
    int                base;
    logic [data_w-1:0] word;
    logic              last_retire;
    for (int i = 0; i < pre_addr.size(); i++) begin
      host_write(pre_addr[i], pre_data[i]);
    end
    for (int i = 0; i < prog.size(); i++) begin
      host_write(addr_w'(i), prog[i]);  // physical page 0
    end
    base = retire_total;
    @(posedge clka);
    start <= 1'b1;
    @(posedge clka);
    start <= 1'b0;
    @(negedge clka);
    assert (busy) else stop_on_error("busy did not rise the cycle after start");
    do begin
      last_retire = retire;
      @(negedge clka);
    end while (busy);
    assert (last_retire) else stop_on_error("busy fell without exit retiring the cycle before");
    check_value({name, " retires"}, 32'(exec_count), 32'(retire_total - base));
    for (int i = 0; i < exp_addr.size(); i++) begin
      host_read(exp_addr[i], word);
      check_value(name, 32'(exp_data[i]), 32'(word));
    end
  endtask

  task automatic host_port_test();
    logic [addr_w-1:0] base;
    logic [addr_w-1:0] addrs [n_host_words];
    logic [data_w-1:0] words [n_host_words];
    logic [data_w-1:0] got;
    base = addr_w'($urandom);
    for (int i = 0; i < n_host_words; i++) begin
      addrs[i] = base + addr_w'(i * 67);  // odd stride, no repeats
      words[i] = data_w'($urandom);
      host_write(addrs[i], words[i]);
    end
    for (int i = 0; i < n_host_words; i++) begin
      host_read(addrs[i], got);
      check_value("host port", 32'(words[i]), 32'(got));
    end
  endtask

  task automatic arith_test();
    int         n_ops;
    int         sel;
    logic [7:0] op;
    new_program();
    n_ops = 8 + int'($urandom_range(15));
    for (int i = 0; i < n_ops; i++) begin
      sel = int'($urandom_range(7));
      if (sel < 3) op = op_num2reg;
      else if (sel < 5) op = op_reg_plus;
      else if (sel < 7) op = op_reg_minus;
      else op = 8'h80 | 8'($urandom_range(127));  // unknown, retires only
      run_instr(op, rand_reg_byte(int'($urandom_range(7))), data_w'($urandom), '0);
    end
    for (int r = 0; r < reg_count; r++) begin
      run_instr(op_reg2ram, rand_reg_byte(r), rand_data_addr(r), '0);
    end
    run_instr(op_exit, '0, '0, '0);
    run_program("arith");
  endtask

  task automatic load_test();
    int n_items;
    int r;
    new_program();
    n_items = 4 + int'($urandom_range(8));
    for (int i = 0; i < n_items; i++) begin
      r = int'($urandom_range(7));
      run_instr(op_ram2reg, rand_reg_byte(r), rand_data_addr(16 + 2 * i), data_w'($urandom));
      run_instr(op_reg2ram, rand_reg_byte(r), rand_data_addr(17 + 2 * i), '0);
    end
    run_instr(op_exit, '0, '0, '0);
    run_program("load");
  endtask

  task automatic jump_test();
    int         n_skip;
    int         target;
    int         sel;
    logic [7:0] op;
    new_program();
    for (int r = 0; r < reg_count; r++) begin
      run_instr(op_num2reg, rand_reg_byte(r), data_w'($urandom), '0);
    end
    n_skip = 1 + int'($urandom_range(5));
    target = prog.size() + 2 + 2 * n_skip;  // word address after the skipped block
    run_instr(op_jmp, rand_reg_byte(0), {(data_w - addr_w)'($urandom), addr_w'(target)}, '0);
    for (int k = 0; k < n_skip; k++) begin
      sel = int'($urandom_range(3));
      op  = (sel == 3) ? 8'(op_exit) : 8'(4 + sel);  // num2reg, plus, minus or exit
      encode(op, rand_reg_byte(int'($urandom_range(7))), data_w'($urandom));  // never runs
    end
    for (int r = 0; r < reg_count; r++) begin
      run_instr(op_reg2ram, rand_reg_byte(r), rand_data_addr(48 + r), '0);
    end
    run_instr(op_exit, '0, '0, '0);
    run_program("jump");
  endtask

  task automatic page_run(input string name);
    new_program();
    for (int r = 0; r < reg_count; r++) begin
      run_instr(op_num2reg, rand_reg_byte(r), data_w'($urandom), '0);
    end
    for (int i = 0; i < 12; i++) begin
      run_instr(op_reg2ram, rand_reg_byte(i % reg_count), rand_data_addr(40 + i), '0);
    end
    run_instr(op_exit, '0, '0, '0);
    run_program(name);
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clka);
    stop_on_error("watchdog expired before all programs finished");
  end

  initial begin
    void'($urandom(32'h5c99240a));
    rst_n      = 1'b0;
    start      = 1'b0;
    host_wr    = 1'b0;
    host_rd    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    model_reset();
    repeat (2) @(posedge clka);
    rst_n <= 1'b1;
    host_port_test();
    for (int i = 0; i < n_arith_runs; i++) arith_test();
    for (int i = 0; i < n_load_runs; i++) load_test();
    for (int i = 0; i < n_jump_runs; i++) jump_test();
    reset_dut();  // fresh map, first touch starts at page 1
    page_run("page first run");
    page_run("page second run");  // mapping from the first run is kept
    $display("No errors");
    $finish;
  end

endmodule
